// ==== build.f ====
cpu_isa_pkg.sv
cpu_bus_pkg.sv
cpu_stage_reg.sv
cpu_fetch.sv
cpu_decode.sv
cpu_regfile.sv
cpu_exec.sv
cpu_core.sv
tb_clock.sv
tb_core.sv

// ==== tb_core.sv ====
module tb_core
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	logic      clk;
	logic      arst_n;
	logic      rst_req;
	logic      rand_ack;
	ibus_req_t ibus_req;
	ibus_rsp_t ibus_rsp;
	retire_t   retire;
	integer    seed = 32'h74ab90b8;
	word_t     imem [64];
	word_t     prog [$];
	reg_idx_t  exp_rd [$];
	word_t     exp_val [$];
	reg_idx_t  got_rd [$];
	word_t     got_val [$];
	string     cur_test = "startup";
	string     mode_tag;
	int        budget_cycles = 20;
	int        n_checks = 0;
	int        n_errors = 0;

	tb_clock u_clock (.i_rst_req(rst_req), .clk(clk), .o_arst_n(arst_n));

	cpu_core u_dut (
		.clk(clk), .i_arst_n(arst_n),
		.o_ibus(ibus_req), .i_ibus(ibus_rsp), .o_retire(retire)
	);

	// ####################
	// instruction memory
	// ####################

	initial begin : imem_model
		int wait_left;
		wait_left = -1;
		ibus_rsp = '0;
		forever begin
			@(posedge clk);
			#2;
			ibus_rsp.ack = 1'b0;
			if (!ibus_req.access) begin
				wait_left = -1;
			end else begin
				if (wait_left < 0) begin
					wait_left = rand_ack ? ($unsigned($random(seed)) % 4) : 0;
				end
				if (wait_left == 0) begin
					ibus_rsp.ack  = 1'b1;
					ibus_rsp.data = imem[ibus_req.addr[5:0]];
					wait_left     = -1;
				end else begin
					wait_left--;
				end
			end
		end
	end

	always @(negedge clk) begin
		if (retire.valid) begin
			got_rd.push_back(retire.rd);
			got_val.push_back(retire.value);
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > budget_cycles) begin
				$display("timeout in %s: %0d of %0d expected writes retired",
					cur_test, got_rd.size(), exp_rd.size());
				$display("Simulation finished: FAIL");
				$finish;
			end
		end
	end

	// ####################
	// reference and checks
	// ####################

	function automatic word_t encode(input opcode_e op, input int rd, input int ra,
		input int rb, input int imm);
		instr_t ins;
		ins.opcode = op;
		ins.rd     = rd[2:0];
		ins.ra     = ra[2:0];
		ins.rb     = rb[2:0];
		ins.rsvd   = '0;
		ins.imm    = imm[15:0];
		return ins;
	endfunction

	// walks the program in imem until the self-jump.
	task automatic model_program(output int steps);
		word_t  regs [NUM_REGS];
		int     pc;
		instr_t ins;
		word_t  a;
		word_t  b;
		word_t  imm;
		word_t  res;
		logic   wr;
		logic   done;
		exp_rd.delete();
		exp_val.delete();
		foreach (regs[i]) regs[i] = '0;
		pc    = 0;
		steps = 0;
		done  = 1'b0;
		while (!done && steps < 1000) begin
			ins = instr_t'(imem[pc[7:2]]);
			a   = regs[ins.ra];
			b   = regs[ins.rb];
			imm = {{16{ins.imm[15]}}, ins.imm};
			res = '0;
			wr  = 1'b1;
			steps++;
			pc  = pc + 4;
			case (ins.opcode)
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_OR:   res = a | b;
				OP_XOR:  res = a ^ b;
				OP_ADDI: res = a + imm;
				OP_LUI:  res = {ins.imm, 16'h0000};
				OP_BEQ: begin
					wr = 1'b0;
					if (a == b) pc = pc + 4 * $signed(imm);
				end
				OP_JMP: begin
					wr   = 1'b0;
					done = (imm == '1); // jump to itself ends the program.
					pc   = pc + 4 * $signed(imm);
				end
				default: wr = 1'b0;
			endcase
			if (wr && ins.rd != '0) begin
				regs[ins.rd] = res;
				exp_rd.push_back(ins.rd);
				exp_val.push_back(res);
			end
		end
	endtask

	task automatic check_value(input string what, input word_t exp, input word_t act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("FAILED %s: expected %h, actual %h", what, exp, act);
		end
	endtask

	task automatic run_program(input string name);
		int steps;
		@(posedge clk);
		#2;
		cur_test = {name, "/", mode_tag};
		rst_req  = 1'b1;
		@(negedge arst_n);
		rst_req = 1'b0;
		for (int i = 0; i < 64; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : {4'hf, 28'(i)}; // 4'hf acts as nop.
		end
		model_program(steps);
		budget_cycles += (steps + 20) * 10;
		got_rd.delete();
		got_val.delete();
		@(posedge arst_n);
		while (got_rd.size() < exp_rd.size()) @(negedge clk);
		repeat (20) @(negedge clk); // the self-jump must stay quiet.
		if (got_rd.size() > exp_rd.size()) begin
			n_errors++;
			$display("%s: %0d extra retirements", cur_test, got_rd.size() - exp_rd.size());
		end
		foreach (exp_rd[i]) begin
			check_value($sformatf("%s write %0d rd", cur_test, i), exp_rd[i], got_rd[i]);
			check_value($sformatf("%s write %0d value", cur_test, i), exp_val[i], got_val[i]);
		end
	endtask

	// ####################
	// directed tests
	// ####################

	task automatic test_alu();
		prog = '{encode(OP_LUI, 1, 0, 0, 'h1234), encode(OP_ADDI, 2, 0, 0, 'h55),
			encode(OP_ADDI, 3, 0, 0, -3), encode(OP_NOP, 0, 0, 0, 0),
			encode(OP_NOP, 0, 0, 0, 0), encode(OP_NOP, 0, 0, 0, 0),
			encode(OP_ADD, 4, 1, 2, 0), encode(OP_SUB, 5, 2, 3, 0),
			encode(OP_AND, 6, 1, 3, 0), encode(OP_OR, 7, 2, 3, 0),
			encode(OP_XOR, 1, 2, 3, 0), encode(OP_ADDI, 0, 2, 0, 7),
			encode(OP_JMP, 0, 0, 0, -1)};
		run_program("alu");
	endtask

	task automatic test_fwd_back();
		prog = '{encode(OP_ADDI, 1, 0, 0, 5), encode(OP_ADD, 2, 1, 1, 0),
			encode(OP_SUB, 3, 2, 1, 0), encode(OP_XOR, 4, 3, 2, 0),
			encode(OP_OR, 5, 4, 4, 0), encode(OP_AND, 6, 5, 2, 0),
			encode(OP_ADDI, 7, 6, 0, 'h100), encode(OP_JMP, 0, 0, 0, -1)};
		run_program("fwd_back");
	endtask

	task automatic test_fwd_two();
		prog = '{encode(OP_ADDI, 1, 0, 0, 7), encode(OP_ADDI, 2, 0, 0, 3),
			encode(OP_SUB, 3, 1, 0, 0), encode(OP_AND, 4, 2, 1, 0),
			encode(OP_LUI, 5, 0, 0, 'h00ff), encode(OP_OR, 6, 4, 0, 0),
			encode(OP_ADD, 7, 5, 6, 0), encode(OP_JMP, 0, 0, 0, -1)};
		run_program("fwd_two");
	endtask

	task automatic test_beq();
		prog = '{encode(OP_ADDI, 1, 0, 0, 4), encode(OP_ADDI, 2, 0, 0, 4),
			encode(OP_BEQ, 0, 1, 2, 2), encode(OP_ADDI, 3, 0, 0, 'h11),
			encode(OP_ADDI, 4, 0, 0, 'h22), encode(OP_ADDI, 5, 0, 0, 'h33),
			encode(OP_BEQ, 0, 1, 5, 1), encode(OP_ADDI, 6, 0, 0, 'h44),
			encode(OP_JMP, 0, 0, 0, -1)};
		run_program("beq");
	endtask

	task automatic test_loop();
		prog = '{encode(OP_ADDI, 1, 0, 0, 5), encode(OP_ADDI, 1, 1, 0, -1),
			encode(OP_BEQ, 0, 1, 0, 1), encode(OP_JMP, 0, 0, 0, -3),
			encode(OP_ADDI, 3, 0, 0, 'h77), encode(OP_JMP, 0, 0, 0, -1)};
		run_program("loop");
	endtask

	task automatic run_all();
		test_alu();
		test_fwd_back();
		test_fwd_two();
		test_beq();
		test_loop();
	endtask

	initial begin
		rst_req  = 1'b0;
		rand_ack = 1'b0;
		mode_tag = "zero_wait";
		wait (arst_n);
		run_all();
		rand_ack = 1'b1;
		mode_tag = "random_wait";
		run_all();
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== tb_clock.sv ====
module tb_clock (
	input  logic i_rst_req,
	output logic clk,
	output logic o_arst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD_NS    = 20;
	localparam int RESET_CYCLES = 4;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset at start, then again on each request.
	initial begin
		forever begin
			o_arst_n = 1'b0;
			repeat (RESET_CYCLES) @(posedge clk);
			#2;
			o_arst_n = 1'b1;
			wait (i_rst_req);
		end
	end

endmodule

// ==== cpu_core.sv ====
module cpu_core
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;
(
	input  logic      clk,
	input  logic      i_arst_n,
	output ibus_req_t o_ibus,
	input  ibus_rsp_t i_ibus,
	output retire_t   o_retire
);

	logic        f_valid;
	fd_payload_t f_data;
	logic        fd_valid;
	fd_payload_t fd_data;
	reg_idx_t    ra_sel;
	reg_idx_t    rb_sel;
	ctrl_t       ctrl;
	word_t       ra_val;
	word_t       rb_val;
	de_payload_t d_data;
	logic        de_valid;
	de_payload_t de_data;
	logic        redirect;
	word_t       target;
	retire_t     retire;

	cpu_fetch u_fetch (
		.clk(clk), .i_arst_n(i_arst_n),
		.o_ibus(o_ibus), .i_ibus(i_ibus),
		.i_redirect(redirect), .i_target(target),
		.o_valid(f_valid), .o_data(f_data)
	);

	cpu_stage_reg #(.payload_t(fd_payload_t)) u_f_d (
		.clk(clk), .i_arst_n(i_arst_n),
		.i_valid(f_valid), .i_data(f_data), .i_flush(redirect),
		.o_valid(fd_valid), .o_data(fd_data)
	);

	cpu_decode u_decode (
		.i_instr(fd_data.instr),
		.o_ra_sel(ra_sel), .o_rb_sel(rb_sel), .o_ctrl(ctrl)
	);

	cpu_regfile u_regfile (
		.clk(clk), .i_arst_n(i_arst_n),
		.i_ra_sel(ra_sel), .i_rb_sel(rb_sel), .o_ra(ra_val), .o_rb(rb_val),
		.i_wr_en(retire.valid), .i_wr_sel(retire.rd), .i_wr_val(retire.value)
	);

	assign d_data = '{
		ctrl: ctrl, ra_sel: ra_sel, rb_sel: rb_sel,
		ra_val: ra_val, rb_val: rb_val, pc_plus_4: fd_data.pc_plus_4
	};

	cpu_stage_reg #(.payload_t(de_payload_t)) u_d_e (
		.clk(clk), .i_arst_n(i_arst_n),
		.i_valid(fd_valid), .i_data(d_data), .i_flush(redirect),
		.o_valid(de_valid), .o_data(de_data)
	);

	cpu_exec u_exec (
		.clk(clk), .i_arst_n(i_arst_n),
		.i_valid(de_valid), .i_data(de_data),
		.o_redirect(redirect), .o_target(target), .o_retire(retire)
	);

	assign o_retire = retire;

endmodule

// ==== cpu_exec.sv ====
module cpu_exec
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;
(
	input  logic        clk,
	input  logic        i_arst_n,
	input  logic        i_valid,
	input  de_payload_t i_data,
	output logic        o_redirect,
	output word_t       o_target,
	output retire_t     o_retire
);

	word_t    op_a;
	word_t    op_b;
	word_t    op2;
	word_t    alu_res;
	logic     wb_valid_q;
	reg_idx_t wb_rd_q;
	word_t    wb_val_q;

	// ####################
	// forwarding
	// ####################

	always_comb begin
		op_a = i_data.ra_val;
		op_b = i_data.rb_val;
		if (wb_valid_q && wb_rd_q == i_data.ra_sel) begin
			op_a = wb_val_q;
		end
		if (wb_valid_q && wb_rd_q == i_data.rb_sel) begin
			op_b = wb_val_q;
		end
	end

	// ####################
	// alu and branch
	// ####################

	assign op2 = i_data.ctrl.op2_imm ? i_data.ctrl.imm32 : op_b;

	always_comb begin
		case (i_data.ctrl.alu_op)
			ALU_SUB: alu_res = op_a - op2;
			ALU_AND: alu_res = op_a & op2;
			ALU_OR:  alu_res = op_a | op2;
			ALU_XOR: alu_res = op_a ^ op2;
			ALU_LUI: alu_res = {op2[15:0], 16'h0000};
			default: alu_res = op_a + op2;
		endcase
	end

	assign o_redirect = i_valid &&
		(i_data.ctrl.is_jmp || (i_data.ctrl.is_beq && op_a == op_b));
	assign o_target = i_data.pc_plus_4 + {i_data.ctrl.imm32[29:0], 2'b00}; // word offset.

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wb_valid_q <= 1'b0;
		end else begin
			wb_valid_q <= i_valid && i_data.ctrl.write_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			wb_rd_q  <= i_data.ctrl.rd;
			wb_val_q <= alu_res;
		end
	end

	assign o_retire = '{valid: wb_valid_q, rd: wb_rd_q, value: wb_val_q};

	// the flush empties d_e, so a redirect never repeats.
	a_redirect_pulse: assert property (
		@(posedge clk) disable iff (!i_arst_n)
		o_redirect |=> !o_redirect
	);

endmodule

// ==== cpu_regfile.sv ====
module cpu_regfile
	import cpu_isa_pkg::*;
(
	input  logic     clk,
	input  logic     i_arst_n,
	input  reg_idx_t i_ra_sel,
	input  reg_idx_t i_rb_sel,
	output word_t    o_ra,
	output word_t    o_rb,
	input  logic     i_wr_en,
	input  reg_idx_t i_wr_sel,
	input  word_t    i_wr_val
);

	word_t regs [1:NUM_REGS-1];

	// same-cycle write shows through to the reader.
	function automatic word_t rd_port(input reg_idx_t sel);
		if (sel == '0) begin
			return '0;
		end else if (i_wr_en && i_wr_sel == sel) begin
			return i_wr_val;
		end
		return regs[sel];
	endfunction

	always_comb begin
		o_ra = rd_port(i_ra_sel);
		o_rb = rd_port(i_rb_sel);
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en && i_wr_sel != '0) begin
			regs[i_wr_sel] <= i_wr_val;
		end
	end

	a_no_r0_write: assert property (
		@(posedge clk) disable iff (!i_arst_n)
		i_wr_en |-> i_wr_sel != '0
	);

endmodule

// ==== cpu_decode.sv ====
module cpu_decode
	import cpu_isa_pkg::*;
(
	input  instr_t   i_instr,
	output reg_idx_t o_ra_sel,
	output reg_idx_t o_rb_sel,
	output ctrl_t    o_ctrl
);

	logic writes_rd;

	assign o_ra_sel = i_instr.ra;
	assign o_rb_sel = i_instr.rb;

	assign writes_rd = i_instr.opcode inside {
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LUI
	};

	// ####################
	// control
	// ####################

	always_comb begin
		o_ctrl       = '0;
		o_ctrl.imm32 = {{16{i_instr.imm[15]}}, i_instr.imm};
		o_ctrl.rd    = i_instr.rd;

		case (i_instr.opcode)
			OP_SUB:  o_ctrl.alu_op = ALU_SUB;
			OP_AND:  o_ctrl.alu_op = ALU_AND;
			OP_OR:   o_ctrl.alu_op = ALU_OR;
			OP_XOR:  o_ctrl.alu_op = ALU_XOR;
			OP_LUI:  o_ctrl.alu_op = ALU_LUI;
			default: o_ctrl.alu_op = ALU_ADD; // add, addi and everything else.
		endcase

		o_ctrl.op2_imm  = i_instr.opcode inside {OP_ADDI, OP_LUI};
		o_ctrl.write_rd = writes_rd && (i_instr.rd != '0); // r0 is never written.
		o_ctrl.is_beq   = i_instr.opcode == OP_BEQ;
		o_ctrl.is_jmp   = i_instr.opcode == OP_JMP;
	end

endmodule

// ==== cpu_fetch.sv ====
module cpu_fetch
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;
(
	input  logic        clk,
	input  logic        i_arst_n,
	output ibus_req_t   o_ibus,
	input  ibus_rsp_t   i_ibus,
	input  logic        i_redirect,
	input  word_t       i_target,
	output logic        o_valid,
	output fd_payload_t o_data
);

	logic        acc_q;
	logic [29:0] addr_q;
	word_t       pc_q;   // next address to put on the bus.
	logic        kill_q;
	logic        issue;
	word_t       next_pc;

	// idle after reset, or the current access completes on this edge.
	assign issue   = !acc_q || i_ibus.ack;
	assign next_pc = i_redirect ? i_target : pc_q;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			acc_q  <= 1'b0;
			addr_q <= '0;
			pc_q   <= RESET_PC;
			kill_q <= 1'b0;
		end else if (issue) begin
			acc_q  <= 1'b1;
			addr_q <= next_pc[31:2];
			pc_q   <= next_pc + 32'd4;
			kill_q <= 1'b0;
		end else if (i_redirect) begin
			// access still pending, let it finish and drop the data.
			pc_q   <= i_target;
			kill_q <= 1'b1;
		end
	end

	assign o_ibus  = '{access: acc_q, addr: addr_q};
	assign o_valid = acc_q && i_ibus.ack && !kill_q;
	assign o_data  = '{
		instr:     instr_t'(i_ibus.data),
		pc_plus_4: {addr_q + 30'd1, 2'b00}
	};

	a_ibus_hold: assert property (
		@(posedge clk) disable iff (!i_arst_n)
		o_ibus.access && !i_ibus.ack |=> o_ibus.access && $stable(o_ibus.addr)
	);

endmodule

// ==== cpu_stage_reg.sv ====
module cpu_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     i_arst_n,
	input  logic     i_valid,
	input  payload_t i_data,
	input  logic     i_flush,
	output logic     o_valid,
	output payload_t o_data
);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid && !i_flush; // flush beats a new capture.
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			o_data <= i_data;
		end
	end

	// a valid slot never carries unknown bits.
	a_valid_known: assert property (
		@(posedge clk) disable iff (!i_arst_n)
		o_valid |-> !$isunknown(o_data)
	);

endmodule

// ==== cpu_bus_pkg.sv ====
package cpu_bus_pkg;
	import cpu_isa_pkg::*;

	typedef struct packed {
		logic        access;
		logic [29:0] addr;  // word address.
	} ibus_req_t;

	typedef struct packed {
		logic  ack;
		word_t data;
	} ibus_rsp_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    value;
	} retire_t;

	typedef struct packed {
		instr_t instr;
		word_t  pc_plus_4;
	} fd_payload_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t ra_sel;
		reg_idx_t rb_sel;
		word_t    ra_val;
		word_t    rb_val;
		word_t    pc_plus_4;
	} de_payload_t;

endpackage

// ==== cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	// ####################
	// basic types
	// ####################

	localparam int NUM_REGS = 8;

	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
	typedef logic [31:0] word_t;

	localparam word_t RESET_PC = 32'h0000_0000;

	// ####################
	// instruction format
	// ####################

	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_ADDI = 4'h6,
		OP_LUI  = 4'h7,
		OP_BEQ  = 4'h8,
		OP_JMP  = 4'h9
	} opcode_e; // 4'ha..4'hf fall through as nop.

	typedef struct packed {
		opcode_e     opcode;
		reg_idx_t    rd;
		reg_idx_t    ra;
		reg_idx_t    rb;
		logic [2:0]  rsvd;
		logic [15:0] imm;
	} instr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_LUI
	} alu_op_e;

	typedef struct packed {
		alu_op_e  alu_op;
		logic     op2_imm;  // second alu operand is imm32.
		word_t    imm32;
		reg_idx_t rd;
		logic     write_rd;
		logic     is_beq;
		logic     is_jmp;
	} ctrl_t;

endpackage
